// File: ctrl_pkg.sv
// Shared types for the RV32 decode stage
// Opcode, ALU, write-back, immediate, mul/div and trap encodings plus the control bundle
package ctrl_pkg;

  // RV32I major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_FENCE  = 7'b0001111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operation, 0 to 9
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Write-back source mux
  typedef enum logic [2:0] {
    WB_ALU    = 3'd0,
    WB_MEM    = 3'd1,
    WB_PC4    = 3'd2,
    WB_CSR    = 3'd3,
    WB_MULDIV = 3'd4
  } wb_sel_e;

  // Immediate format
  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_sel_e;

  // M-extension op, same code as funct3
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  // Trap kind out of SYSTEM
  typedef enum logic [1:0] {
    SYS_NONE   = 2'd0,
    SYS_ECALL  = 2'd1,
    SYS_EBREAK = 2'd2,
    SYS_MRET   = 2'd3
  } sys_op_e;

  typedef logic [31:0] inst_t;

  // Decoded control bundle
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jump;
    alu_op_e  alu_op;
    logic     alu_src;   // 1 = immediate operand
    wb_sel_e  wb_sel;
    imm_sel_e imm_sel;
    logic     csr_we;
    logic     csr_src;   // 1 = zimm, 0 = rs1
    logic     md_en;
    md_op_e   md_op;
    sys_op_e  sys_op;
    logic     illegal;
  } ctrl_t;

  localparam logic [6:0] F7_MULDIV   = 7'b0000001;  // funct7 of MUL/DIV group
  localparam inst_t      INST_ECALL  = 32'h0000_0073;
  localparam inst_t      INST_EBREAK = 32'h0010_0073;
  localparam inst_t      INST_MRET   = 32'h3020_0073;

endpackage

// File: decode_properties.sv
// Concurrent checks on the decode stage outputs
// Attached to the decode stage by bind
`timescale 1ns/1ps

module decode_properties (
  input logic            clk,
  input logic            rst,
  input logic            out_valid,
  input ctrl_pkg::ctrl_t ctrl
);
  import ctrl_pkg::*;

  // Valid bit cleared on the edge after reset
  a_reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // Illegal bundles carry no side effects
  a_illegal_is_inert: assert property (@(posedge clk) disable iff (rst)
      (out_valid && ctrl.illegal) |-> !(ctrl.reg_write || ctrl.mem_read || ctrl.mem_write))
    else $error("illegal bundle with a write or memory access");

  a_mem_exclusive: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> !(ctrl.mem_read && ctrl.mem_write))
    else $error("mem_read and mem_write both set");

  // Mul/div result path
  a_md_writeback: assert property (@(posedge clk) disable iff (rst)
      (out_valid && ctrl.md_en) |-> (ctrl.wb_sel == WB_MULDIV))
    else $error("md_en without the MULDIV write-back source");

endmodule

bind decode_stage decode_properties decode_properties_inst (
  .clk       (clk),
  .rst       (rst),
  .out_valid (out_valid),
  .ctrl      (ctrl)
);

// File: decode_stage.sv
// Registered RV32 decode stage
// One instruction per cycle in, control bundle out one cycle later
`timescale 1ns/1ps

module decode_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,   // Per-cycle strobe, no back-pressure
  input  ctrl_pkg::inst_t  instr,
  output logic             out_valid,
  output ctrl_pkg::ctrl_t  ctrl
);
  import ctrl_pkg::*;

  ctrl_t ctrl_next;  // Combinational decode result

  main_control main_control_inst (
    .instr (instr),
    .ctrl  (ctrl_next)
  );

  // Valid pipe bit, the only state that reset clears
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Payload register, holds its value through gaps
  always_ff @(posedge clk) begin
    if (in_valid) begin
      ctrl <= ctrl_next;
    end
  end

endmodule

// File: main_control.sv
// Opcode-level control generation for RV32IM plus SYSTEM
// Merges the ALU/M-op and SYSTEM sub-decoders into one control bundle
`timescale 1ns/1ps

module main_control (
  input  ctrl_pkg::inst_t  instr,
  output ctrl_pkg::ctrl_t  ctrl
);
  import ctrl_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_reg_op;

  alu_op_e    dec_alu_op;
  logic       dec_md_en;
  md_op_e     dec_md_op;

  logic       sys_csr_we;
  logic       sys_csr_src;
  sys_op_e    sys_op;
  logic       sys_illegal;

  // Instruction fields
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign is_reg_op = (opcode == OPC_OP);  // R-type vs I-type ALU op

  op_decode op_decode_inst (
    .funct3    (funct3),
    .funct7    (funct7),
    .is_reg_op (is_reg_op),
    .alu_op    (dec_alu_op),
    .md_en     (dec_md_en),
    .md_op     (dec_md_op)
  );

  system_decode system_decode_inst (
    .instr       (instr),
    .csr_we      (sys_csr_we),
    .csr_src     (sys_csr_src),
    .sys_op      (sys_op),
    .sys_illegal (sys_illegal)
  );

  always_comb begin
    // Defaults, a NOP bundle
    ctrl         = '0;
    ctrl.alu_op  = ALU_ADD;
    ctrl.wb_sel  = WB_ALU;
    ctrl.imm_sel = IMM_I;
    ctrl.md_op   = MD_MUL;
    ctrl.sys_op  = SYS_NONE;

    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.imm_sel   = IMM_U;
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = WB_PC4;   // Link address
        ctrl.imm_sel   = IMM_J;
      end
      OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.alu_src   = 1'b1;     // rs1 + imm target
        ctrl.wb_sel    = WB_PC4;
      end
      OPC_BRANCH: begin
        ctrl.branch  = 1'b1;
        ctrl.alu_op  = ALU_SUB;    // Compare by subtraction
        ctrl.imm_sel = IMM_B;
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;     // Address = rs1 + offset
        ctrl.wb_sel    = WB_MEM;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.imm_sel   = IMM_S;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = dec_alu_op;
      end
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        if (dec_md_en) begin
          // Result from the mul/div unit, ALU idle at ADD
          ctrl.md_en  = 1'b1;
          ctrl.md_op  = dec_md_op;
          ctrl.wb_sel = WB_MULDIV;
        end else begin
          ctrl.alu_op = dec_alu_op;
        end
      end
      OPC_FENCE: begin
        // Treated as a NOP
      end
      OPC_SYSTEM: begin
        ctrl.csr_we  = sys_csr_we;
        ctrl.csr_src = sys_csr_src;
        ctrl.sys_op  = sys_op;
        if (sys_csr_we) begin
          ctrl.reg_write = 1'b1;   // Old CSR value to rd
          ctrl.wb_sel    = WB_CSR;
        end
        ctrl.illegal = sys_illegal;
      end
      default: begin
        ctrl.illegal = 1'b1;       // RV64 W ops, AMO, FP and unknown opcodes
      end
    endcase
  end

endmodule

// File: op_decode.sv
// ALU and M-extension operation decode for OP and OP-IMM
// Pure combinational, opcode is qualified by the caller
`timescale 1ns/1ps

module op_decode (
  input  logic [2:0]         funct3,
  input  logic [6:0]         funct7,
  input  logic               is_reg_op,  // Register form, enables SUB and M ops
  output ctrl_pkg::alu_op_e  alu_op,
  output logic               md_en,
  output ctrl_pkg::md_op_e   md_op
);
  import ctrl_pkg::*;

  // funct3 to ALU op
  always_comb begin
    unique case (funct3)
      3'b000: begin
        // Immediate form has no SUB
        if (is_reg_op && funct7[5]) begin
          alu_op = ALU_SUB;
        end else begin
          alu_op = ALU_ADD;
        end
      end
      3'b001: alu_op = ALU_SLL;
      3'b010: alu_op = ALU_SLT;
      3'b011: alu_op = ALU_SLTU;
      3'b100: alu_op = ALU_XOR;
      3'b101: begin
        if (funct7[5]) begin  // imm[10] for SRAI
          alu_op = ALU_SRA;
        end else begin
          alu_op = ALU_SRL;
        end
      end
      3'b110: alu_op = ALU_OR;
      3'b111: alu_op = ALU_AND;
      default: alu_op = ALU_ADD;
    endcase
  end

  // MUL/DIV group only in register form
  assign md_en = is_reg_op && (funct7 == F7_MULDIV);
  assign md_op = md_op_e'(funct3);  // Op code is funct3 itself

endmodule

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
  --top-module tb_decode_stage -o sim_tb_decode_stage
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb_decode_stage)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "TEST PASSED"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// File: system_decode.sv
// SYSTEM instruction decode
// CSR access control, trap kind and legality of the funct3 space
`timescale 1ns/1ps

module system_decode (
  input  ctrl_pkg::inst_t    instr,
  output logic               csr_we,
  output logic               csr_src,
  output ctrl_pkg::sys_op_e  sys_op,
  output logic               sys_illegal
);
  import ctrl_pkg::*;

  logic [2:0] funct3;

  assign funct3 = instr[14:12];

  always_comb begin
    csr_we      = 1'b0;
    csr_src     = 1'b0;
    sys_op      = SYS_NONE;
    sys_illegal = 1'b0;

    unique case (funct3)
      3'b000: begin
        // Privileged group, whole word must match
        if (instr == INST_ECALL) begin
          sys_op = SYS_ECALL;
        end else if (instr == INST_EBREAK) begin
          sys_op = SYS_EBREAK;
        end else if (instr == INST_MRET) begin
          sys_op = SYS_MRET;
        end else begin
          sys_illegal = 1'b1;  // SRET, WFI, SFENCE.VMA and junk
        end
      end
      3'b100: begin
        sys_illegal = 1'b1;    // Reserved funct3
      end
      default: begin
        // CSRRW/S/C and immediate forms
        csr_we  = 1'b1;        // Write suppression left to the core
        csr_src = funct3[2];   // Immediate forms use zimm
      end
    endcase
  end

endmodule

// File: tb_decode_stage.sv
// Testbench for the registered RV32 decode stage
// Directed and random instructions checked against a reference decode model
`timescale 1ns/1ps

module tb_decode_stage;
  import ctrl_pkg::*;

  localparam int unsigned SEED         = 82454;
  localparam int          RESET_CYCLES = 8;
  localparam int unsigned NUM_DIRECTED = 15;
  localparam int          NUM_RANDOM   = 4000;
  localparam int          DRAIN_LIMIT  = 20;  // Cycles allowed for the stream to go idle

  logic  clk;
  logic  rst;
  logic  in_valid;
  inst_t instr;
  logic  out_valid;
  ctrl_t ctrl;

  ctrl_t exp_q[$];    // Bundles in flight, one per accepted instruction
  string name_q[$];   // Matching test names
  ctrl_t held_ctrl;   // Last bundle seen at the output
  logic  held_known;
  logic  pend_valid;  // in_valid driven for the coming edge
  int    checks;
  int    errors;
  int    timeouts;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  decode_stage decode_stage_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .out_valid (out_valid),
    .ctrl      (ctrl)
  );

  // Reference ALU op, SUB only in register form
  function automatic alu_op_e model_alu(input logic [2:0] f3, input logic f7b5,
                                        input logic reg_form);
    alu_op_e op;
    case (f3)
      3'd0: op = (reg_form && f7b5) ? ALU_SUB : ALU_ADD;
      3'd1: op = ALU_SLL;
      3'd2: op = ALU_SLT;
      3'd3: op = ALU_SLTU;
      3'd4: op = ALU_XOR;
      3'd5: op = f7b5 ? ALU_SRA : ALU_SRL;  // Arithmetic shift flag
      3'd6: op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Reference decode of one instruction word
  function automatic ctrl_t expected_ctrl(input inst_t w);
    ctrl_t      c;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc       = w[6:0];
    f3        = w[14:12];
    f7        = w[31:25];
    c         = '0;
    c.alu_op  = ALU_ADD;
    c.wb_sel  = WB_ALU;
    c.imm_sel = IMM_I;
    c.md_op   = MD_MUL;
    c.sys_op  = SYS_NONE;
    if (opc == OPC_LUI || opc == OPC_AUIPC) begin
      c.reg_write = 1'b1;
      c.alu_src   = 1'b1;
      c.imm_sel   = IMM_U;
    end else if (opc == OPC_JAL) begin
      c.reg_write = 1'b1;
      c.jump      = 1'b1;
      c.wb_sel    = WB_PC4;
      c.imm_sel   = IMM_J;
    end else if (opc == OPC_JALR) begin
      c.reg_write = 1'b1;
      c.jump      = 1'b1;
      c.alu_src   = 1'b1;
      c.wb_sel    = WB_PC4;
    end else if (opc == OPC_BRANCH) begin
      c.branch  = 1'b1;
      c.alu_op  = ALU_SUB;
      c.imm_sel = IMM_B;
    end else if (opc == OPC_LOAD) begin
      c.reg_write = 1'b1;
      c.mem_read  = 1'b1;
      c.alu_src   = 1'b1;
      c.wb_sel    = WB_MEM;
    end else if (opc == OPC_STORE) begin
      c.mem_write = 1'b1;
      c.alu_src   = 1'b1;
      c.imm_sel   = IMM_S;
    end else if (opc == OPC_OP_IMM) begin
      c.reg_write = 1'b1;
      c.alu_src   = 1'b1;
      c.alu_op    = model_alu(f3, f7[5], 1'b0);
    end else if (opc == OPC_OP) begin
      c.reg_write = 1'b1;
      if (f7 == F7_MULDIV) begin
        c.md_en  = 1'b1;
        c.md_op  = md_op_e'(f3);
        c.wb_sel = WB_MULDIV;
      end else begin
        c.alu_op = model_alu(f3, f7[5], 1'b1);
      end
    end else if (opc == OPC_FENCE) begin
      // NOP bundle
    end else if (opc == OPC_SYSTEM) begin
      if (f3 == 3'b000) begin
        if (w == INST_ECALL) c.sys_op = SYS_ECALL;
        else if (w == INST_EBREAK) c.sys_op = SYS_EBREAK;
        else if (w == INST_MRET) c.sys_op = SYS_MRET;
        else c.illegal = 1'b1;  // Any other privileged word
      end else if (f3 == 3'b100) begin
        c.illegal = 1'b1;
      end else begin
        c.csr_we    = 1'b1;
        c.csr_src   = f3[2];     // zimm forms
        c.reg_write = 1'b1;
        c.wb_sel    = WB_CSR;
      end
    end else begin
      c.illegal = 1'b1;
    end
    return c;
  endfunction

  function automatic logic [6:0] legal_opcode(input int unsigned k);
    case (k)
      0: return OPC_LUI;
      1: return OPC_AUIPC;
      2: return OPC_JAL;
      3: return OPC_JALR;
      4: return OPC_BRANCH;
      5: return OPC_LOAD;
      6: return OPC_STORE;
      7: return OPC_OP_IMM;
      8: return OPC_OP;
      9: return OPC_FENCE;
      default: return OPC_SYSTEM;
    endcase
  endfunction

  // RV64 W, AMO and FP majors, illegal in this stage
  function automatic logic [6:0] foreign_opcode(input int unsigned k);
    case (k)
      0: return 7'b0011011;        // OP-IMM-32
      1: return 7'b0111011;        // OP-32
      2: return 7'b0101111;        // AMO
      3: return 7'b0000111;        // LOAD-FP
      4: return 7'b0100111;        // STORE-FP
      default: return 7'b1010011;  // OP-FP
    endcase
  endfunction

  function automatic inst_t random_instr();
    inst_t       w;
    int unsigned pick;
    w    = $urandom();
    pick = $urandom_range(0, 99);
    if (pick < 75) begin
      w[6:0] = legal_opcode($urandom_range(0, 10));
    end else if (pick < 90) begin
      w[6:0] = foreign_opcode($urandom_range(0, 5));
    end
    // funct7 bias toward the decoded values
    case ($urandom_range(0, 3))
      0: w[31:25] = 7'b0000000;
      1: w[31:25] = 7'b0100000;
      2: w[31:25] = F7_MULDIV;
      default: ;
    endcase
    if (w[6:0] == OPC_SYSTEM) begin
      pick = $urandom_range(0, 7);
      if (pick == 0) w = INST_ECALL;
      else if (pick == 1) w = INST_EBREAK;
      else if (pick == 2) w = INST_MRET;
      else if (pick == 3) w[14:12] = 3'b000;  // Malformed privileged word
    end
    return w;
  endfunction

  function automatic inst_t directed_instr(input int unsigned k);
    case (k)
      0: return INST_ECALL;
      1: return INST_EBREAK;
      2: return INST_MRET;
      3: return 32'h3400_9073;   // csrrw x0, mscratch, x1
      4: return 32'h3004_6073;   // csrrsi x0, mstatus, 8
      5: return 32'h1020_0073;   // SRET
      6: return 32'h1050_0073;   // WFI
      7: return 32'h0000_4073;   // SYSTEM funct3 100
      8: return 32'h0220_0033;   // mul
      9: return 32'h4020_8033;   // sub
      10: return 32'h4020_8013;  // addi, imm bit 10 set
      11: return 32'h4050_d013;  // srai
      12: return 32'h0020_803b;  // addw
      13: return 32'h0000_0000;
      default: return 32'h0000_000f;  // fence
    endcase
  endfunction

  function automatic string case_name(input inst_t w);
    case (w[6:0])
      OPC_LUI: return "lui";
      OPC_AUIPC: return "auipc";
      OPC_JAL: return "jal";
      OPC_JALR: return "jalr";
      OPC_BRANCH: return "branch";
      OPC_LOAD: return "load";
      OPC_STORE: return "store";
      OPC_OP_IMM: return "op_imm";
      OPC_OP: return "op";
      OPC_FENCE: return "fence";
      OPC_SYSTEM: return "system";
      default: return "illegal_opcode";
    endcase
  endfunction

  // Drive one cycle of input, queue the expected bundle
  task automatic apply_input(input logic v, input inst_t w);
    in_valid   = v;
    instr      = w;
    pend_valid = v;
    if (v) begin
      exp_q.push_back(expected_ctrl(w));
      name_q.push_back($sformatf("%s_%08h", case_name(w), w));
    end
  endtask

  // Compare the outputs of the last edge
  task automatic check_outputs();
    ctrl_t want;
    string name;
    checks++;
    if (out_valid !== pend_valid) begin
      errors++;
      $display("FAIL out_valid expected %0b actual %0b", pend_valid, out_valid);
    end
    if (pend_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: a bundle was due but none was queued");
      end else begin
        want = exp_q.pop_front();
        name = name_q.pop_front();
        checks++;
        if (ctrl !== want) begin
          errors++;
          $display("FAIL %s expected 0x%07h actual 0x%07h", name, want, ctrl);
        end
        held_ctrl  = want;
        held_known = 1'b1;
      end
    end else if (held_known) begin
      checks++;
      if (ctrl !== held_ctrl) begin  // Gap, payload must hold
        errors++;
        $display("FAIL ctrl_hold expected 0x%07h actual 0x%07h", held_ctrl, ctrl);
      end
    end
  endtask

  initial begin
    int wait_cycles;
    rst        = 1'b1;
    in_valid   = 1'b1;  // Strobe high through reset, rst alone must hold out_valid low
    instr      = '0;
    pend_valid = 1'b0;
    held_known = 1'b0;
    held_ctrl  = '0;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) @(negedge clk);
    checks++;
    if (out_valid !== 1'b0) begin
      errors++;
      $display("FAIL reset_out_valid expected 0 actual %0b", out_valid);
    end
    rst = 1'b0;

    // Directed words back to back, then one gap
    for (int unsigned k = 0; k < NUM_DIRECTED; k++) begin
      apply_input(1'b1, directed_instr(k));
      @(negedge clk);
      check_outputs();
    end
    apply_input(1'b0, random_instr());
    @(negedge clk);
    check_outputs();

    // Random stream with random gaps
    for (int n = 0; n < NUM_RANDOM; n++) begin
      apply_input($urandom_range(0, 3) != 0, random_instr());
      @(negedge clk);
      check_outputs();
    end

    // Let the pipe go idle
    apply_input(1'b0, '0);
    wait_cycles = 0;
    while ((out_valid !== 1'b0 || exp_q.size() != 0) && wait_cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      check_outputs();
      wait_cycles++;
    end
    if (out_valid !== 1'b0 || exp_q.size() != 0) begin
      timeouts++;
      $display("ERROR: timed out waiting for the output stream to go idle");
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
ctrl_pkg.sv
op_decode.sv
system_decode.sv
main_control.sv
decode_stage.sv
decode_properties.sv
tb_decode_stage.sv
